// File: de0_nano_params.svh
// widths, register map and cycle counts for the de0 nano fabric logic, include in RTL and testbench
`ifndef DE0_NANO_PARAMS_SVH
`define DE0_NANO_PARAMS_SVH

// ============================================================
// widths
// ============================================================
`define BUS_WIDTH           32      // cpu strobe bus data
`define ADDR_WIDTH          3       // word address, eight registers
`define GPIO_WIDTH          32      // pins per header bank
`define KEY_COUNT           2       // push buttons
`define LED_COUNT           8       // board leds, bit 0 is heartbeat

// ============================================================
// timing in fpga_clk_50 cycles
// ============================================================
`define DEBOUNCE_CYCLES     16      // stable cycles before a key level is taken
`define RESET_PULSE_CYCLES  8       // width of any hps reset request
`define COLD_HOLD_CYCLES    64      // both keys held this long for cold request
`define HEARTBEAT_CYCLES    32      // half period of led[0]

// ============================================================
// register word addresses
// ============================================================
`define REG_BANK0_OUT       3'd0    // rw
`define REG_BANK0_OE        3'd1    // rw
`define REG_BANK0_IN        3'd2    // ro, synchronized pins
`define REG_BANK1_OUT       3'd3    // rw
`define REG_BANK1_OE        3'd4    // rw
`define REG_BANK1_IN        3'd5    // ro
`define REG_LED             3'd6    // rw, bits 6:0 to led[7:1]
`define REG_BUTTONS         3'd7    // keys 1:0, pending 9:8 w1c

`endif

// File: de0_nano_pkg.sv
// shared vector types and reset fsm states for the de0 nano fabric logic, use as de0_nano_pkg::name
`include "de0_nano_params.svh"

package de0_nano_pkg;

	// ============================================================
	// bus and pin vectors
	// ============================================================
	typedef logic [`BUS_WIDTH-1:0]  bus_data_t;   // one bus word
	typedef logic [`ADDR_WIDTH-1:0] bus_addr_t;   // register word address
	typedef logic [`GPIO_WIDTH-1:0] gpio_bank_t;  // one header bank
	typedef logic [`KEY_COUNT-1:0]  key_t;        // active low buttons
	typedef logic [`LED_COUNT-1:0]  led_t;        // board leds

	// reset request fsm
	// idle also counts the both-held time
	typedef enum logic [1:0] {
		idle         = 2'd0,   // waiting for a press
		pulse        = 2'd1,   // one request line high
		wait_release = 2'd2    // after cold, until both keys up
	} reset_state_t;

endpackage

// File: key_debounce.sv
// two-flop synchronizer and stability filter for the active low push buttons, used by the top level
`timescale 1ns/10ps
`include "de0_nano_params.svh"

module key_debounce #(
	parameter int CNT_MAX = `DEBOUNCE_CYCLES   // stable cycles needed
) (
	input  logic                fpga_clk_50,
	input  logic                arst_n,
	input  de0_nano_pkg::key_t  key,       // raw pins, async
	output de0_nano_pkg::key_t  keys_db    // accepted level
);

	localparam int CNT_W = $clog2(CNT_MAX + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CNT_MAX - 1);

	de0_nano_pkg::key_t  sync1;                  // metastability stage
	de0_nano_pkg::key_t  sync2;                  // safe to use
	logic [CNT_W-1:0]    cnt [`KEY_COUNT];       // per key stability count

	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync1   <= '1;     // released
			sync2   <= '1;
			keys_db <= '1;
			for (int i = 0; i < `KEY_COUNT; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			sync1 <= key;
			sync2 <= sync1;
			for (int i = 0; i < `KEY_COUNT; i++) begin
				if (sync2[i] == keys_db[i]) begin
					cnt[i] <= '0;                  // no change pending, or bounced back
				end else if (cnt[i] == CNT_LAST) begin
					keys_db[i] <= sync2[i];        // held long enough
					cnt[i]     <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// File: hps_board_ctrl.sv
// turns debounced button presses into hps cold, warm and debug reset pulses and blinks the heartbeat
`timescale 1ns/10ps
`include "de0_nano_params.svh"

module hps_board_ctrl (
	input  logic                fpga_clk_50,
	input  logic                arst_n,
	input  de0_nano_pkg::key_t  keys_db,          // debounced, low = pressed
	output logic                hps_cold_reset,   // active high requests
	output logic                hps_warm_reset,
	output logic                hps_debug_reset,
	output logic                heartbeat         // led[0]
);

	localparam int PULSE_W = $clog2(`RESET_PULSE_CYCLES + 1);
	localparam int HOLD_W  = $clog2(`COLD_HOLD_CYCLES + 1);
	localparam int HB_W    = $clog2(`HEARTBEAT_CYCLES + 1);
	localparam logic [PULSE_W-1:0] PULSE_LAST = PULSE_W'(`RESET_PULSE_CYCLES - 1);
	localparam logic [HOLD_W-1:0]  HOLD_LAST  = HOLD_W'(`COLD_HOLD_CYCLES - 1);
	localparam logic [HB_W-1:0]    HB_LAST    = HB_W'(`HEARTBEAT_CYCLES - 1);

	de0_nano_pkg::reset_state_t  state;
	de0_nano_pkg::key_t          keys_q;      // last cycle, for edges
	logic                        press0;
	logic                        press1;
	logic                        both_held;
	logic [PULSE_W-1:0]          pulse_cnt;
	logic [HOLD_W-1:0]           hold_cnt;
	logic [HB_W-1:0]             hb_cnt;

	assign press0    = keys_q[0] & ~keys_db[0];   // falling edge = press
	assign press1    = keys_q[1] & ~keys_db[1];
	assign both_held = ~keys_db[0] & ~keys_db[1];

	// ============================================================
	// reset request fsm
	// ============================================================
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			state           <= de0_nano_pkg::idle;
			keys_q          <= '1;
			pulse_cnt       <= '0;
			hold_cnt        <= '0;
			hps_cold_reset  <= 1'b0;
			hps_warm_reset  <= 1'b0;
			hps_debug_reset <= 1'b0;
		end else begin
			keys_q <= keys_db;
			case (state)
				de0_nano_pkg::idle: begin
					pulse_cnt <= '0;
					if (both_held) begin
						if (hold_cnt == HOLD_LAST) begin
							hold_cnt       <= '0;
							hps_cold_reset <= 1'b1;   // held the full time
							state          <= de0_nano_pkg::pulse;
						end else begin
							hold_cnt <= hold_cnt + 1'b1;
						end
					end else begin
						hold_cnt <= '0;
						if (press0 && keys_db[1]) begin          // key 0 alone
							hps_warm_reset <= 1'b1;
							state          <= de0_nano_pkg::pulse;
						end else if (press1 && keys_db[0]) begin // key 1 alone
							hps_debug_reset <= 1'b1;
							state           <= de0_nano_pkg::pulse;
						end
					end
				end
				de0_nano_pkg::pulse: begin
					if (pulse_cnt == PULSE_LAST) begin
						pulse_cnt       <= '0;
						hps_cold_reset  <= 1'b0;
						hps_warm_reset  <= 1'b0;
						hps_debug_reset <= 1'b0;
						// cold must see both keys up before anything else
						state <= hps_cold_reset ? de0_nano_pkg::wait_release : de0_nano_pkg::idle;
					end else begin
						pulse_cnt <= pulse_cnt + 1'b1;
					end
				end
				de0_nano_pkg::wait_release: begin
					if (keys_db == '1) begin
						state <= de0_nano_pkg::idle;
					end
				end
				default: state <= de0_nano_pkg::idle;
			endcase
		end
	end

	// ============================================================
	// heartbeat
	// ============================================================
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			hb_cnt    <= '0;
			heartbeat <= 1'b0;
		end else if (hb_cnt == HB_LAST) begin
			hb_cnt    <= '0;
			heartbeat <= ~heartbeat;   // half period done
		end else begin
			hb_cnt <= hb_cnt + 1'b1;
		end
	end

endmodule

// File: gpio_regs.sv
// register block on the cpu strobe bus for two gpio banks, the leds and the button change interrupt
`timescale 1ns/10ps
`include "de0_nano_params.svh"

module gpio_regs (
	input  logic                      fpga_clk_50,
	input  logic                      arst_n,

	// cpu strobe bus, no wait states
	input  logic                      cpu_chip_sel,
	input  logic                      cpu_read,
	input  logic                      cpu_write,
	input  de0_nano_pkg::bus_addr_t   cpu_addr,
	input  de0_nano_pkg::bus_data_t   cpu_wdata,
	output de0_nano_pkg::bus_data_t   cpu_rdata,   // valid one cycle after read

	input  de0_nano_pkg::key_t        keys_db,
	output logic                      irq,         // any pending change
	output logic [`LED_COUNT-2:0]     led_reg,     // to led[7:1]

	input  de0_nano_pkg::gpio_bank_t  gpio0_in,
	output de0_nano_pkg::gpio_bank_t  gpio0_out,
	output de0_nano_pkg::gpio_bank_t  gpio0_oe,
	input  de0_nano_pkg::gpio_bank_t  gpio1_in,
	output de0_nano_pkg::gpio_bank_t  gpio1_out,
	output de0_nano_pkg::gpio_bank_t  gpio1_oe
);

	localparam int PEND_LSB = 8;   // pending flags sit at 9:8 in REG_BUTTONS

	logic                      wr_en;
	logic                      rd_en;
	de0_nano_pkg::gpio_bank_t  gpio0_s1;    // first sync stage
	de0_nano_pkg::gpio_bank_t  gpio0_s2;
	de0_nano_pkg::gpio_bank_t  gpio1_s1;
	de0_nano_pkg::gpio_bank_t  gpio1_s2;
	de0_nano_pkg::key_t        keys_q;      // for change detect
	de0_nano_pkg::key_t        key_chg;
	de0_nano_pkg::key_t        pend_clr;
	de0_nano_pkg::key_t        pending;
	de0_nano_pkg::bus_data_t   rd_mux;

	assign wr_en = cpu_chip_sel & cpu_write;
	assign rd_en = cpu_chip_sel & cpu_read;

	// ============================================================
	// writable registers
	// ============================================================
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			gpio0_out <= '0;
			gpio0_oe  <= '0;     // all pins input after reset
			gpio1_out <= '0;
			gpio1_oe  <= '0;
			led_reg   <= '0;
		end else if (wr_en) begin
			case (cpu_addr)
				`REG_BANK0_OUT: gpio0_out <= cpu_wdata;
				`REG_BANK0_OE:  gpio0_oe  <= cpu_wdata;
				`REG_BANK1_OUT: gpio1_out <= cpu_wdata;
				`REG_BANK1_OE:  gpio1_oe  <= cpu_wdata;
				`REG_LED:       led_reg   <= cpu_wdata[`LED_COUNT-2:0];
				default: ;      // ro addresses, buttons handled below
			endcase
		end
	end

	// input pins, two flops per bank
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			gpio0_s1 <= '0;
			gpio0_s2 <= '0;
			gpio1_s1 <= '0;
			gpio1_s2 <= '0;
		end else begin
			gpio0_s1 <= gpio0_in;
			gpio0_s2 <= gpio0_s1;
			gpio1_s1 <= gpio1_in;
			gpio1_s2 <= gpio1_s1;
		end
	end

	// ============================================================
	// button change flags and interrupt
	// ============================================================
	assign key_chg  = keys_q ^ keys_db;   // either direction
	assign pend_clr = (wr_en && cpu_addr == `REG_BUTTONS) ?
		cpu_wdata[PEND_LSB +: `KEY_COUNT] : '0;

	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			keys_q  <= '1;       // matches debouncer reset level
			pending <= '0;
		end else begin
			keys_q  <= keys_db;
			pending <= (pending & ~pend_clr) | key_chg;   // new change beats clear
		end
	end

	assign irq = |pending;

	// ============================================================
	// read path
	// ============================================================
	always_comb begin
		rd_mux = '0;
		case (cpu_addr)
			`REG_BANK0_OUT: rd_mux = gpio0_out;
			`REG_BANK0_OE:  rd_mux = gpio0_oe;
			`REG_BANK0_IN:  rd_mux = gpio0_s2;
			`REG_BANK1_OUT: rd_mux = gpio1_out;
			`REG_BANK1_OE:  rd_mux = gpio1_oe;
			`REG_BANK1_IN:  rd_mux = gpio1_s2;
			`REG_LED:       rd_mux[`LED_COUNT-2:0] = led_reg;
			`REG_BUTTONS: begin
				rd_mux[`KEY_COUNT-1:0]           = keys_db;
				rd_mux[PEND_LSB +: `KEY_COUNT]   = pending;
			end
			default: rd_mux = '0;
		endcase
	end

	// holds until the next read
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			cpu_rdata <= '0;
		end else if (rd_en) begin
			cpu_rdata <= rd_mux;
		end
	end

endmodule

// File: de0_nano_top.sv
// fabric top level of the de0 nano board, connects buttons, hps reset requests and gpio registers
`timescale 1ns/10ps
`include "de0_nano_params.svh"

module de0_nano_top (
	input  logic                      fpga_clk_50,   // board 50 MHz
	input  logic                      arst_n,
	input  de0_nano_pkg::key_t        key,           // push buttons, low when pressed

	// cpu strobe bus
	input  logic                      cpu_chip_sel,
	input  logic                      cpu_read,
	input  logic                      cpu_write,
	input  de0_nano_pkg::bus_addr_t   cpu_addr,
	input  de0_nano_pkg::bus_data_t   cpu_wdata,
	output de0_nano_pkg::bus_data_t   cpu_rdata,
	output logic                      irq,           // button change

	output de0_nano_pkg::led_t        led,
	output logic                      hps_cold_reset,
	output logic                      hps_warm_reset,
	output logic                      hps_debug_reset,

	// header banks, split tristate
	input  de0_nano_pkg::gpio_bank_t  gpio0_in,
	output de0_nano_pkg::gpio_bank_t  gpio0_out,
	output de0_nano_pkg::gpio_bank_t  gpio0_oe,
	input  de0_nano_pkg::gpio_bank_t  gpio1_in,
	output de0_nano_pkg::gpio_bank_t  gpio1_out,
	output de0_nano_pkg::gpio_bank_t  gpio1_oe
);

	de0_nano_pkg::key_t        keys_db;     // debounced, still active low
	logic                      heartbeat;
	logic [`LED_COUNT-2:0]     led_reg;     // cpu owned leds

	// heartbeat on led 0, register on the rest
	assign led = {led_reg, heartbeat};

	// ============================================================
	// buttons
	// ============================================================
	key_debounce i_key_debounce (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.key         (key),
		.keys_db     (keys_db)
	);

	hps_board_ctrl i_hps_board_ctrl (
		.fpga_clk_50     (fpga_clk_50),
		.arst_n          (arst_n),
		.keys_db         (keys_db),
		.hps_cold_reset  (hps_cold_reset),
		.hps_warm_reset  (hps_warm_reset),
		.hps_debug_reset (hps_debug_reset),
		.heartbeat       (heartbeat)
	);

	// ============================================================
	// register block
	// ============================================================
	gpio_regs i_gpio_regs (
		.fpga_clk_50  (fpga_clk_50),
		.arst_n       (arst_n),
		.cpu_chip_sel (cpu_chip_sel),
		.cpu_read     (cpu_read),
		.cpu_write    (cpu_write),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_rdata    (cpu_rdata),
		.keys_db      (keys_db),
		.irq          (irq),
		.led_reg      (led_reg),
		.gpio0_in     (gpio0_in),
		.gpio0_out    (gpio0_out),
		.gpio0_oe     (gpio0_oe),
		.gpio1_in     (gpio1_in),
		.gpio1_out    (gpio1_out),
		.gpio1_oe     (gpio1_oe)
	);

endmodule

// File: tb_clk_gen.sv
// free running testbench clock for tb_de0_nano, instantiate once and take clk
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD = 8    // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;                     // first rising edge at half period
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// File: tb_de0_nano.sv
// simulation top that drives de0_nano_top through register, button and reset request tests
`timescale 1ns/10ps
`include "de0_nano_params.svh"

module tb_de0_nano;

	localparam int PERIOD = 8;   // ns
	// rough test lengths in cycles for the watchdog
	localparam int T_RESET      = 30;
	localparam int T_GPIO_OUT   = 8 * 26;
	localparam int T_GPIO_IN    = 4 * 16;
	localparam int T_BUTTON     = 4 * `DEBOUNCE_CYCLES + 60;
	localparam int T_WARM_DEBUG = 2 * (2 * `DEBOUNCE_CYCLES + `RESET_PULSE_CYCLES + 30);
	localparam int T_COLD = 2 * `COLD_HOLD_CYCLES + 2 * `DEBOUNCE_CYCLES + `RESET_PULSE_CYCLES + 40;
	localparam int RUN_CYCLES = T_RESET + T_GPIO_OUT + T_GPIO_IN + T_BUTTON + T_WARM_DEBUG + T_COLD;

	logic                       clk;
	logic                       arst_n;
	de0_nano_pkg::key_t         key;
	logic                       cpu_chip_sel;
	logic                       cpu_read;
	logic                       cpu_write;
	de0_nano_pkg::bus_addr_t    cpu_addr;
	de0_nano_pkg::bus_data_t    cpu_wdata;
	de0_nano_pkg::bus_data_t    cpu_rdata;
	logic                       irq;
	de0_nano_pkg::led_t         led;
	logic                       hps_cold_reset;
	logic                       hps_warm_reset;
	logic                       hps_debug_reset;
	de0_nano_pkg::gpio_bank_t   gpio0_in;
	de0_nano_pkg::gpio_bank_t   gpio0_out;
	de0_nano_pkg::gpio_bank_t   gpio0_oe;
	de0_nano_pkg::gpio_bank_t   gpio1_in;
	de0_nano_pkg::gpio_bank_t   gpio1_out;
	de0_nano_pkg::gpio_bank_t   gpio1_oe;

	// register map model
	de0_nano_pkg::gpio_bank_t   m_out0;
	de0_nano_pkg::gpio_bank_t   m_oe0;
	de0_nano_pkg::gpio_bank_t   m_in0;
	de0_nano_pkg::gpio_bank_t   m_out1;
	de0_nano_pkg::gpio_bank_t   m_oe1;
	de0_nano_pkg::gpio_bank_t   m_in1;
	logic [`LED_COUNT-2:0]      m_led;
	de0_nano_pkg::key_t         m_keys;       // debounced level with low for pressed
	de0_nano_pkg::key_t         m_pend;

	bit                         chk_valid;    // read accepted last edge
	de0_nano_pkg::bus_addr_t    chk_addr;
	de0_nano_pkg::bus_data_t    chk_exp;
	int                         n_reads;
	int                         read_errors;  // owned by the compare process
	int                         errors;       // owned by the main sequence
	int                         err_base;
	int                         n_tests;

	logic [2:0]                 req;          // 0 cold, 1 warm, 2 debug
	bit [2:0]                   req_q;
	int                         pulse_cnt [3];
	int                         high_cnt [3];
	int                         pulse_base [3];
	int                         high_base [3];

	bit                         hb_last;      // led[0] level, low out of reset
	int                         hb_len;       // cycles since the last led[0] edge
	int                         hb_toggles;
	int                         hb_errors;    // owned by the heartbeat monitor

	assign req = {hps_debug_reset, hps_warm_reset, hps_cold_reset};

	tb_clk_gen #(.PERIOD(PERIOD)) i_tb_clk_gen (.clk(clk));

	de0_nano_top i_de0_nano_top (
		.fpga_clk_50 (clk), .arst_n (arst_n), .key (key),
		.cpu_chip_sel (cpu_chip_sel), .cpu_read (cpu_read), .cpu_write (cpu_write),
		.cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata), .cpu_rdata (cpu_rdata), .irq (irq),
		.led (led), .hps_cold_reset (hps_cold_reset), .hps_warm_reset (hps_warm_reset),
		.hps_debug_reset (hps_debug_reset),
		.gpio0_in (gpio0_in), .gpio0_out (gpio0_out), .gpio0_oe (gpio0_oe),
		.gpio1_in (gpio1_in), .gpio1_out (gpio1_out), .gpio1_oe (gpio1_oe)
	);

	// ============================================================
	// reference model and compare
	// ============================================================
	function automatic de0_nano_pkg::bus_data_t ref_reg(input de0_nano_pkg::bus_addr_t a);
		de0_nano_pkg::bus_data_t v;
		v = '0;                               // unused bits read zero
		case (a)
			`REG_BANK0_OUT: v = m_out0;
			`REG_BANK0_OE:  v = m_oe0;
			`REG_BANK0_IN:  v = m_in0;
			`REG_BANK1_OUT: v = m_out1;
			`REG_BANK1_OE:  v = m_oe1;
			`REG_BANK1_IN:  v = m_in1;
			`REG_LED:       v[`LED_COUNT-2:0] = m_led;
			default: begin                    // buttons
				v[`KEY_COUNT-1:0] = m_keys;
				v[8 +: `KEY_COUNT] = m_pend;
			end
		endcase
		return v;
	endfunction

	// expected value taken at the accepting edge
	always @(posedge clk) begin
		chk_valid <= cpu_chip_sel & cpu_read;
		chk_addr  <= cpu_addr;
		chk_exp   <= ref_reg(cpu_addr);
	end

	always @(negedge clk) begin
		if (chk_valid) begin
			n_reads++;
			if (cpu_rdata !== chk_exp) begin
				read_errors++;
				$display("Fail %0t: read addr %0d got %h, expected %h",
					$time, chk_addr, cpu_rdata, chk_exp);
			end
		end
	end

	// reset request pulses counted mid cycle
	always @(negedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (req[i]) begin
				high_cnt[i]++;
			end
			if (req[i] && !req_q[i]) begin
				pulse_cnt[i]++;               // rising edge
			end
		end
		req_q = req;
	end

	// heartbeat half period on led[0] from reset release on
	always @(negedge clk) begin
		if (arst_n) begin
			if (led[0] !== hb_last) begin
				if (hb_len != `HEARTBEAT_CYCLES) begin
					hb_errors++;
					$display("Fail %0t: heartbeat half period %0d cycles, expected %0d",
						$time, hb_len, `HEARTBEAT_CYCLES);
				end
				hb_toggles++;
				hb_len  = 1;
				hb_last = led[0];
			end else begin
				hb_len++;
			end
		end
	end

	// watchdog
	initial begin
		#(2 * RUN_CYCLES * PERIOD);
		$display("watchdog expired, the tests did not finish within %0d cycles", 2 * RUN_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// ============================================================
	// helpers
	// ============================================================
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;                                   // drive point
	endtask

	task automatic log_fail(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	task automatic model_write(input de0_nano_pkg::bus_addr_t a, input de0_nano_pkg::bus_data_t d);
		case (a)
			`REG_BANK0_OUT: m_out0 = d;
			`REG_BANK0_OE:  m_oe0 = d;
			`REG_BANK1_OUT: m_out1 = d;
			`REG_BANK1_OE:  m_oe1 = d;
			`REG_LED:       m_led = d[`LED_COUNT-2:0];
			`REG_BUTTONS:   m_pend = m_pend & ~d[8 +: `KEY_COUNT];   // write one clears
			default: ;                        // input banks ignore writes
		endcase
	endtask

	task automatic bus_write(input de0_nano_pkg::bus_addr_t a, input de0_nano_pkg::bus_data_t d);
		@(posedge clk);
		#1;
		cpu_chip_sel = 1'b1;
		cpu_write    = 1'b1;
		cpu_addr     = a;
		cpu_wdata    = d;
		wait_cycles(1);                       // taken on this edge
		cpu_chip_sel = 1'b0;
		cpu_write    = 1'b0;
		model_write(a, d);
	endtask

	task automatic bus_read(input de0_nano_pkg::bus_addr_t a);
		@(posedge clk);
		#1;
		cpu_chip_sel = 1'b1;
		cpu_read     = 1'b1;
		cpu_addr     = a;
		wait_cycles(1);
		cpu_chip_sel = 1'b0;
		cpu_read     = 1'b0;
	endtask

	task automatic wait_irq(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		while (irq !== level && n < max_cycles) begin
			wait_cycles(1);
			n++;
		end
		if (irq !== level) begin
			errors++;
			$display("irq did not go to %0b within %0d cycles after %s", level, max_cycles, what);
		end
	endtask

	task automatic snap_pulses();
		pulse_base = pulse_cnt;
		high_base  = high_cnt;
	endtask

	function automatic string req_label(input int i);
		case (i)
			0: return "cold";
			1: return "warm";
			default: return "debug";
		endcase
	endfunction

	// count and width of each request since the last snapshot
	task automatic check_pulses(input int n_cold, input int n_warm, input int n_debug);
		int exp_n [3];
		int n;
		int w;
		exp_n = '{n_cold, n_warm, n_debug};
		for (int i = 0; i < 3; i++) begin
			n = pulse_cnt[i] - pulse_base[i];
			w = high_cnt[i] - high_base[i];
			if (n != exp_n[i]) begin
				log_fail($sformatf("%s pulses %0d, expected %0d", req_label(i), n, exp_n[i]));
			end else if (w != exp_n[i] * `RESET_PULSE_CYCLES) begin
				log_fail($sformatf("%s pulse high %0d cycles, expected %0d",
					req_label(i), w, exp_n[i] * `RESET_PULSE_CYCLES));
			end
		end
	endtask

	task automatic report_test(input string name);
		int n;
		wait_cycles(2);                       // last compare done
		n = errors + read_errors + hb_errors - err_base;
		$display("test %-16s %s", name, n == 0 ? "ok" : $sformatf("%0d errors", n));
		err_base = errors + read_errors + hb_errors;
		n_tests++;
	endtask

	// ============================================================
	// test sequence
	// ============================================================
	initial begin
		arst_n = 1'b0;
		key = '1;                             // released
		cpu_chip_sel = 1'b0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		gpio0_in = '0;
		gpio1_in = '0;
		{m_out0, m_oe0, m_in0, m_out1, m_oe1, m_in1} = '0;
		m_led = '0;
		m_keys = '1;
		m_pend = '0;
		void'($urandom(32'h1cb0));
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// 1 reset values
		for (int a = 0; a < 8; a++) begin
			bus_read(de0_nano_pkg::bus_addr_t'(a));
		end
		if (req !== 3'b000 || irq !== 1'b0) begin
			log_fail("reset request or irq high after reset");
		end
		if (led[`LED_COUNT-1:1] !== '0 || gpio0_oe !== '0 || gpio1_oe !== '0) begin
			log_fail("led or output enable not zero after reset");
		end
		report_test("reset values");

		// 2 output registers and ignored input bank writes
		for (int i = 0; i < 8; i++) begin
			bus_write(`REG_BANK0_OUT, $urandom);
			bus_write(`REG_BANK0_OE, $urandom);
			bus_write(`REG_BANK1_OUT, $urandom);
			bus_write(`REG_BANK1_OE, $urandom);
			bus_write(`REG_BANK0_IN, $urandom);
			bus_write(`REG_BANK1_IN, $urandom);
			if (gpio0_out !== m_out0 || gpio0_oe !== m_oe0 ||
				gpio1_out !== m_out1 || gpio1_oe !== m_oe1) begin
				log_fail("gpio pins differ from the written registers");
			end
			for (int a = 0; a < 6; a++) begin
				bus_read(de0_nano_pkg::bus_addr_t'(a));
			end
		end
		report_test("gpio outputs");

		// 3 input pins and leds
		for (int i = 0; i < 4; i++) begin
			gpio0_in = $urandom;
			gpio1_in = $urandom;
			m_in0 = gpio0_in;
			m_in1 = gpio1_in;
			wait_cycles(3);                   // through the synchronizer
			bus_read(`REG_BANK0_IN);
			bus_read(`REG_BANK1_IN);
			bus_write(`REG_LED, $urandom);
			if (led[`LED_COUNT-1:1] !== m_led) begin
				log_fail($sformatf("led[7:1] %h, expected %h", led[`LED_COUNT-1:1], m_led));
			end
			bus_read(`REG_LED);
		end
		report_test("gpio inputs, leds");

		// 4 button change and irq
		key[0] = 1'b0;                        // short bounce
		wait_cycles(`DEBOUNCE_CYCLES / 2);
		key[0] = 1'b1;
		wait_cycles(`DEBOUNCE_CYCLES + 8);
		if (irq !== 1'b0) begin
			log_fail("irq raised by a bounce shorter than the debounce time");
		end
		bus_read(`REG_BUTTONS);
		key[0] = 1'b0;
		wait_irq(1'b1, `DEBOUNCE_CYCLES + 4, "key 0 press");
		m_keys = 2'b10;
		m_pend = 2'b01;
		bus_read(`REG_BUTTONS);
		bus_write(`REG_BUTTONS, 32'h100);
		if (irq !== 1'b0) begin
			log_fail("irq still high after the pending bit was cleared");
		end
		bus_read(`REG_BUTTONS);
		key[0] = 1'b1;
		wait_irq(1'b1, `DEBOUNCE_CYCLES + 4, "key 0 release");
		m_keys = 2'b11;
		m_pend = 2'b01;
		bus_read(`REG_BUTTONS);
		bus_write(`REG_BUTTONS, 32'h300);
		report_test("buttons, irq");

		// 5 warm then debug with one key at a time
		snap_pulses();
		key = 2'b10;
		wait_cycles(`DEBOUNCE_CYCLES + `RESET_PULSE_CYCLES + 8);
		key = 2'b11;
		wait_cycles(`DEBOUNCE_CYCLES + 8);
		check_pulses(0, 1, 0);
		snap_pulses();
		key = 2'b01;
		wait_cycles(`DEBOUNCE_CYCLES + `RESET_PULSE_CYCLES + 8);
		key = 2'b11;
		wait_cycles(`DEBOUNCE_CYCLES + 8);
		check_pulses(0, 0, 1);
		report_test("warm, debug");

		// 6 both keys held for cold
		// held over two hold times so a repeated cold request would show
		snap_pulses();
		key = 2'b00;
		wait_cycles(`DEBOUNCE_CYCLES + 2 * `COLD_HOLD_CYCLES + `RESET_PULSE_CYCLES + 12);
		key = 2'b11;
		wait_cycles(`DEBOUNCE_CYCLES + 8);
		check_pulses(1, 0, 0);
		report_test("cold");

		// 7 heartbeat, timed all run by its monitor
		if (hb_toggles < 2) begin
			errors++;
			$display("heartbeat on led[0] did not toggle during the run");
		end
		report_test("heartbeat");

		$display("tests %0d, reads checked %0d, errors %0d", n_tests, n_reads,
			errors + read_errors + hb_errors);
		if (errors + read_errors + hb_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: de0_nano_gpio.f
+incdir+.
de0_nano_pkg.sv
key_debounce.sv
hps_board_ctrl.sv
gpio_regs.sv
de0_nano_top.sv
tb_clk_gen.sv
tb_de0_nano.sv

// File: Makefile
TOP := tb_de0_nano

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		-f de0_nano_gpio.f -o sim

# exit status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
